//--- axi_pkg.sv
`default_nettype none

`include "dma_macros.svh"

package axi_pkg;

    // byte address on the AR channel
    typedef logic [31:0] addr_t;

    // one R beat
    typedef logic [`DMA_DATA_BYTES*8-1:0] data_t;

    // beats seen so far in the current burst
    typedef logic [$clog2(`DMA_BURST_LEN + 1)-1:0] beat_cnt_t;

    // burst reader FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACTIVE,
        RD_DRAIN
    } reader_state_e;

endpackage

`default_nettype wire

//--- burst_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_macros.svh"

module burst_reader (
    input  logic                    M_AXI_ACLK,
    input  logic                    M_AXI_ARESETN,
    input  logic                    frame_start,
    input  axi_pkg::addr_t          frame_base,
    input  frame_pkg::burst_cnt_t   frame_bursts,
    input  logic                    burst_credit,
    input  logic                    arready,
    input  axi_pkg::data_t          rdata,
    input  logic                    rlast,
    input  logic                    rvalid,
    output axi_pkg::addr_t          araddr,
    output logic                    arvalid,
    output logic                    rready,
    output logic                    word_valid,
    output axi_pkg::data_t          word_data,
    output logic                    frame_done,
    output logic                    frame_busy
);

    import axi_pkg::*;

    localparam int CRED_W = $clog2(`DMA_FIFO_BURSTS + 1);

    reader_state_e          state;
    logic [CRED_W-1:0]      credits;
    logic [CRED_W-1:0]      credit_nxt;
    logic [CRED_W-1:0]      outstanding;
    frame_pkg::burst_cnt_t  ar_left;
    frame_pkg::burst_cnt_t  ar_left_nxt;
    beat_cnt_t              beat_cnt;
    logic                   ar_hs;
    logic                   r_hs;
    logic                   r_end;
    logic                   want_ar;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;
    assign r_end = r_hs && rlast;

    // one credit per burst slot in the unpacker buffer
    assign credit_nxt  = credits - CRED_W'(ar_hs) + CRED_W'(burst_credit);
    assign ar_left_nxt = ar_left - frame_pkg::burst_cnt_t'(ar_hs);

    // arvalid stays up while a request waits, since its credit is not spent yet
    always_comb begin
        if (frame_start) begin
            want_ar = (frame_bursts != '0) && (credit_nxt != '0);
        end else begin
            want_ar = (state == RD_ACTIVE) && (ar_left_nxt != '0) && (credit_nxt != '0);
        end
    end

    assign rready     = (outstanding != '0);
    assign word_valid = r_hs;
    assign word_data  = rdata;

    // an empty frame finishes at once
    assign frame_done = (state == RD_DRAIN && outstanding == CRED_W'(1) && r_end)
                     || (frame_start && frame_bursts == '0);
    assign frame_busy = frame_start || (state != RD_IDLE);

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state       <= RD_IDLE;
            credits     <= CRED_W'(`DMA_FIFO_BURSTS);
            outstanding <= '0;
            ar_left     <= '0;
            beat_cnt    <= '0;
            arvalid     <= 1'b0;
        end else begin
            credits     <= credit_nxt;
            arvalid     <= want_ar;
            outstanding <= outstanding + CRED_W'(ar_hs) - CRED_W'(r_end);
            if (frame_start) begin
                ar_left <= frame_bursts;
            end else begin
                ar_left <= ar_left_nxt;
            end
            if (r_end) begin
                beat_cnt <= '0;
            end else if (r_hs) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            case (state)
                RD_IDLE: begin
                    if (frame_start && frame_bursts != '0) begin
                        state <= RD_ACTIVE;
                    end
                end
                RD_ACTIVE: begin
                    // last request accepted, wait for its data
                    if (ar_hs && ar_left_nxt == '0) begin
                        state <= RD_DRAIN;
                    end
                end
                RD_DRAIN: begin
                    if (frame_done) begin
                        state <= RD_IDLE;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // burst address walks up by one burst per request
    always_ff @(posedge M_AXI_ACLK) begin
        if (frame_start) begin
            araddr <= frame_base;
        end else if (ar_hs) begin
            araddr <= araddr + addr_t'(`DMA_BURST_BYTES);
        end
    end

    a_ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        arvalid && !arready |=> arvalid && $stable(araddr));

    a_ar_credit: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        ar_hs |-> credits != '0);

    a_rlast_pos: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        r_hs |-> (rlast == (beat_cnt == beat_cnt_t'(`DMA_BURST_LEN - 1))));

endmodule

`default_nettype wire

//--- dma_frame_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_macros.svh"

module dma_frame_reader (
    input  logic                    M_AXI_ACLK,
    input  logic                    M_AXI_ARESETN,
    output logic                    m_axi_arid,
    output axi_pkg::addr_t          m_axi_araddr,
    output logic [7:0]              m_axi_arlen,
    output logic [2:0]              m_axi_arsize,
    output logic [1:0]              m_axi_arburst,
    output logic                    m_axi_arvalid,
    input  logic                    m_axi_arready,
    input  axi_pkg::data_t          m_axi_rdata,
    input  logic                    m_axi_rlast,
    input  logic                    m_axi_rvalid,
    output logic                    m_axi_rready,
    input  frame_pkg::buf_index_t   wr_index,
    input  logic                    rd_start,
    input  logic                    ps_access,
    input  frame_pkg::d_size_t      d_size,
    output logic                    frame_busy,
    output logic                    pix_valid,
    output frame_pkg::pixel_t       pix_data,
    input  logic                    pix_credit
);

    import axi_pkg::*;
    import frame_pkg::*;

    logic           frame_start;
    logic           frame_done;
    addr_t          frame_base;
    burst_cnt_t     frame_bursts;
    logic           burst_credit;
    logic           word_valid;
    data_t          word_data;

    // fixed request shape, single ID
    assign m_axi_arid    = 1'b0;
    assign m_axi_arlen   = 8'(`DMA_BURST_LEN - 1);
    assign m_axi_arsize  = 3'($clog2(`DMA_DATA_BYTES));
    // INCR
    assign m_axi_arburst = 2'b01;

    frame_select u_frame_select (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .wr_index       (wr_index),
        .rd_start       (rd_start),
        .ps_access      (ps_access),
        .d_size         (d_size),
        .frame_done     (frame_done),
        .frame_start    (frame_start),
        .frame_base     (frame_base),
        .frame_bursts   (frame_bursts)
    );

    burst_reader u_burst_reader (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .frame_start    (frame_start),
        .frame_base     (frame_base),
        .frame_bursts   (frame_bursts),
        .burst_credit   (burst_credit),
        .arready        (m_axi_arready),
        .rdata          (m_axi_rdata),
        .rlast          (m_axi_rlast),
        .rvalid         (m_axi_rvalid),
        .araddr         (m_axi_araddr),
        .arvalid        (m_axi_arvalid),
        .rready         (m_axi_rready),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .frame_done     (frame_done),
        .frame_busy     (frame_busy)
    );

    pixel_unpacker u_pixel_unpacker (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .pix_credit     (pix_credit),
        .pix_valid      (pix_valid),
        .pix_data       (pix_data),
        .burst_credit   (burst_credit)
    );

endmodule

`default_nettype wire

//--- dma_macros.svh
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// beats per AXI burst, kept short for simulation
`define DMA_BURST_LEN       16

// bytes per 64-bit beat
`define DMA_DATA_BYTES      8

// bytes covered by one burst
`define DMA_BURST_BYTES     (`DMA_BURST_LEN * `DMA_DATA_BYTES)

// 16-bit pixels packed in one beat
`define DMA_PIX_PER_BEAT    (`DMA_DATA_BYTES / 2)
`define DMA_PIX_PER_BURST   (`DMA_BURST_LEN * `DMA_PIX_PER_BEAT)

// triple frame buffer
`define DMA_BUFF_NUM        3

// read-start pulses before the reader arms
`define DMA_ARM_COUNT       4

// unpacker buffer size in bursts, also the burst credit pool
`define DMA_FIFO_BURSTS     4
`define DMA_FIFO_DEPTH      (`DMA_FIFO_BURSTS * `DMA_BURST_LEN)

// start of buffer 1
`define DMA_RD_BASE         32'h0200_0000

`endif

//--- filelist.f
+incdir+.
axi_pkg.sv
frame_pkg.sv
frame_select.sv
burst_reader.sv
pixel_unpacker.sv
dma_frame_reader.sv
tb_dma_frame_reader.sv

//--- frame_pkg.sv
`default_nettype none

package frame_pkg;

    // frame buffer index, counts from 1
    typedef logic [7:0] buf_index_t;

    // one output pixel
    typedef logic [15:0] pixel_t;

    // runtime frame size in pixels
    typedef logic [23:0] d_size_t;

    // bursts per frame
    typedef logic [15:0] burst_cnt_t;

    // frame selector FSM
    typedef enum logic [1:0] {
        FR_DISARMED,
        FR_ARMED,
        FR_READING
    } frame_state_e;

endpackage

`default_nettype wire

//--- frame_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_macros.svh"

module frame_select (
    input  logic                    M_AXI_ACLK,
    input  logic                    M_AXI_ARESETN,
    input  frame_pkg::buf_index_t   wr_index,
    input  logic                    rd_start,
    input  logic                    ps_access,
    input  frame_pkg::d_size_t      d_size,
    input  logic                    frame_done,
    output logic                    frame_start,
    output axi_pkg::addr_t          frame_base,
    output frame_pkg::burst_cnt_t   frame_bursts
);

    import axi_pkg::*;
    import frame_pkg::*;

    localparam int ARM_W = $clog2(`DMA_ARM_COUNT + 1);

    frame_state_e       state;
    logic [ARM_W-1:0]   arm_cnt;
    logic               ps_q;
    logic               ps_rise;
    logic               start_pend;
    d_size_t            size_q;
    buf_index_t         rd_index_q;
    addr_t              frame_bytes;

    assign ps_rise = ps_access && !ps_q;

    // two bytes per pixel
    assign frame_bytes = addr_t'({size_q, 1'b0});

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state       <= FR_DISARMED;
            arm_cnt     <= '0;
            ps_q        <= 1'b0;
            start_pend  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            ps_q        <= ps_access;
            start_pend  <= 1'b0;
            // second stage of the start pipeline
            frame_start <= start_pend;
            case (state)
                FR_DISARMED: begin
                    if (rd_start) begin
                        arm_cnt <= arm_cnt + 1'b1;
                        if (arm_cnt == ARM_W'(`DMA_ARM_COUNT - 1)) begin
                            state <= FR_ARMED;
                        end
                    end
                end
                FR_ARMED: begin
                    if (ps_rise) begin
                        state      <= FR_READING;
                        start_pend <= 1'b1;
                    end
                end
                FR_READING: begin
                    // access edges here are dropped
                    if (frame_done) begin
                        state <= FR_ARMED;
                    end
                end
                default: begin
                    state <= FR_DISARMED;
                end
            endcase
        end
    end

    // capture on the edge, compute one cycle later
    always_ff @(posedge M_AXI_ACLK) begin
        if (state == FR_ARMED && ps_rise) begin
            size_q <= d_size;
            // read the buffer one behind the writer
            if (wr_index > 8'd1) begin
                rd_index_q <= wr_index - 8'd1;
            end else begin
                rd_index_q <= buf_index_t'(`DMA_BUFF_NUM);
            end
        end
        if (start_pend) begin
            frame_base   <= addr_t'(`DMA_RD_BASE) + addr_t'(rd_index_q - 8'd1) * frame_bytes;
            // partial last burst is dropped
            frame_bursts <= burst_cnt_t'(size_q / `DMA_PIX_PER_BURST);
        end
    end

endmodule

`default_nettype wire

//--- pixel_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_macros.svh"

module pixel_unpacker (
    input  logic                M_AXI_ACLK,
    input  logic                M_AXI_ARESETN,
    input  logic                word_valid,
    input  axi_pkg::data_t      word_data,
    input  logic                pix_credit,
    output logic                pix_valid,
    output frame_pkg::pixel_t   pix_data,
    output logic                burst_credit
);

    import axi_pkg::*;
    import frame_pkg::*;

    localparam int DEPTH  = `DMA_FIFO_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int FILL_W = PTR_W + 1;
    localparam int SEL_W  = $clog2(`DMA_PIX_PER_BEAT);
    localparam int PIX_W  = $clog2(`DMA_PIX_PER_BURST);
    localparam int PX_B   = $bits(pixel_t);

    data_t              mem [DEPTH];
    data_t              head;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [FILL_W-1:0]  fill;
    logic [SEL_W-1:0]   half_sel;
    logic [PIX_W-1:0]   pix_cnt;
    logic [15:0]        pend_cred;
    logic               word_pop;

    assign head = mem[rd_ptr];

    // halfword 0 goes out first
    assign pix_data  = head[half_sel*PX_B +: PX_B];
    assign pix_valid = (fill != '0) && (pend_cred != '0);
    assign word_pop  = pix_valid && (half_sel == SEL_W'(`DMA_PIX_PER_BEAT - 1));

    always_ff @(posedge M_AXI_ACLK) begin
        if (word_valid) begin
            mem[wr_ptr] <= word_data;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill         <= '0;
            half_sel     <= '0;
            pix_cnt      <= '0;
            pend_cred    <= '0;
            burst_credit <= 1'b0;
        end else begin
            fill      <= fill + FILL_W'(word_valid) - FILL_W'(word_pop);
            // grants in, pixels out
            pend_cred <= pend_cred + 16'(pix_credit) - 16'(pix_valid);
            if (word_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pix_valid) begin
                half_sel <= half_sel + 1'b1;
                pix_cnt  <= pix_cnt + 1'b1;
            end
            if (word_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // a whole burst has left, its slot is free again
            burst_credit <= pix_valid && (pix_cnt == PIX_W'(`DMA_PIX_PER_BURST - 1));
        end
    end

    // burst credits upstream must keep the buffer from overflowing
    a_no_overflow: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        word_valid |-> fill != FILL_W'(DEPTH));

    // consumer grants must not wrap the credit counter
    a_cred_wrap: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        pix_credit && !pix_valid |-> pend_cred != '1);

endmodule

`default_nettype wire

//--- tb_dma_frame_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_macros.svh"

module tb_dma_frame_reader;

    import axi_pkg::*;
    import frame_pkg::*;

    localparam int CLK_NS = 100;
    localparam logic [31:0] SEED = 32'h6582c299;
    // frames of 128, 192 and 130 pixels
    localparam int TOTAL_BEATS = (128 / `DMA_PIX_PER_BURST + 192 / `DMA_PIX_PER_BURST
                                 + 130 / `DMA_PIX_PER_BURST) * `DMA_BURST_LEN;

    logic           M_AXI_ACLK;
    logic           M_AXI_ARESETN;
    logic           m_axi_arid;
    addr_t          m_axi_araddr;
    logic [7:0]     m_axi_arlen;
    logic [2:0]     m_axi_arsize;
    logic [1:0]     m_axi_arburst;
    logic           m_axi_arvalid;
    logic           m_axi_arready;
    data_t          m_axi_rdata;
    logic           m_axi_rlast;
    logic           m_axi_rvalid;
    logic           m_axi_rready;
    buf_index_t     wr_index;
    logic           rd_start;
    logic           ps_access;
    d_size_t        d_size;
    logic           frame_busy;
    logic           pix_valid;
    pixel_t         pix_data;
    logic           pix_credit;

    addr_t          exp_ar[$];
    addr_t          ar_pend[$];
    pixel_t         exp_pix[$];
    logic [31:0]    rng = SEED;
    logic           ar_fire = 1'b0;
    logic           r_fire = 1'b0;
    logic           busy_q = 1'b0;
    int             start_pulses = 0;
    int             ar_total = 0;
    int             rlast_total = 0;
    int             pix_sent = 0;
    int             cred_granted = 0;
    int             frame_ars = 0;
    int             frame_beats = 0;
    int             frames_done = 0;
    int             cur_bursts = 0;

    dma_frame_reader u_dut (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .M_AXI_ARESETN  (M_AXI_ARESETN),
        .m_axi_arid     (m_axi_arid),
        .m_axi_araddr   (m_axi_araddr),
        .m_axi_arlen    (m_axi_arlen),
        .m_axi_arsize   (m_axi_arsize),
        .m_axi_arburst  (m_axi_arburst),
        .m_axi_arvalid  (m_axi_arvalid),
        .m_axi_arready  (m_axi_arready),
        .m_axi_rdata    (m_axi_rdata),
        .m_axi_rlast    (m_axi_rlast),
        .m_axi_rvalid   (m_axi_rvalid),
        .m_axi_rready   (m_axi_rready),
        .wr_index       (wr_index),
        .rd_start       (rd_start),
        .ps_access      (ps_access),
        .d_size         (d_size),
        .frame_busy     (frame_busy),
        .pix_valid      (pix_valid),
        .pix_data       (pix_data),
        .pix_credit     (pix_credit)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory contents, a hash of the byte address
    function automatic data_t beat_word(input addr_t addr);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = lcg_step(addr ^ SEED);
        hi = lcg_step(lo ^ ~addr);
        return {hi, lo};
    endfunction

    task automatic fail_check(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic pulse_start();
        @(posedge M_AXI_ACLK);
        #1;
        rd_start = 1'b1;
        start_pulses++;
        @(posedge M_AXI_ACLK);
        #1;
        rd_start = 1'b0;
    endtask

    task automatic pulse_access();
        @(posedge M_AXI_ACLK);
        #1;
        ps_access = 1'b1;
        @(posedge M_AXI_ACLK);
        #1;
        ps_access = 1'b0;
    endtask

    // expected bursts and pixels come straight from the frame rules
    task automatic run_frame(input buf_index_t widx, input d_size_t size);
        buf_index_t ridx;
        addr_t      base;
        addr_t      addr;
        data_t      word;
        int         target;
        #1;
        ridx = (widx > 8'd1) ? widx - 8'd1 : buf_index_t'(`DMA_BUFF_NUM);
        base = `DMA_RD_BASE + (addr_t'(ridx) - 32'd1) * (addr_t'(size) * 32'd2);
        cur_bursts = int'(size) / `DMA_PIX_PER_BURST;
        for (int k = 0; k < cur_bursts; k++) begin
            exp_ar.push_back(base + addr_t'(k * `DMA_BURST_BYTES));
            for (int b = 0; b < `DMA_BURST_LEN; b++) begin
                addr = base + addr_t'(k * `DMA_BURST_BYTES + b * `DMA_DATA_BYTES);
                word = beat_word(addr);
                for (int h = 0; h < `DMA_PIX_PER_BEAT; h++) begin
                    exp_pix.push_back(word[h*16 +: 16]);
                end
            end
        end
        frame_ars = 0;
        frame_beats = 0;
        target = frames_done + 1;
        wr_index = widx;
        d_size = size;
        pulse_access();
        do @(posedge M_AXI_ACLK); while (frames_done != target);
        while (exp_pix.size() != 0) @(posedge M_AXI_ACLK);
        // a spare credit exposes any pixel left over after the frame
        while (cred_granted <= pix_sent) @(posedge M_AXI_ACLK);
        @(posedge M_AXI_ACLK);
    endtask

    initial begin : clock_gen
        M_AXI_ACLK = 1'b0;
        forever #(CLK_NS / 2) M_AXI_ACLK = ~M_AXI_ACLK;
    end

    // handshakes sampled mid-cycle, where everything is settled
    always @(negedge M_AXI_ACLK) begin : monitor
        addr_t  exp_addr;
        pixel_t exp_px;
        if (M_AXI_ARESETN) begin
            ar_fire = m_axi_arvalid && m_axi_arready;
            r_fire = m_axi_rvalid && m_axi_rready;
            if (ar_fire) begin
                assert (exp_ar.size() != 0) else fail_check("AR handshake with no burst left");
                exp_addr = exp_ar.pop_front();
                assert (m_axi_araddr == exp_addr)
                    else fail_check($sformatf("ARADDR %h, expected %h", m_axi_araddr, exp_addr));
                assert (m_axi_arlen == 8'(`DMA_BURST_LEN - 1))
                    else fail_check($sformatf("ARLEN %0d", m_axi_arlen));
                // single ID, 8-byte beats, INCR
                assert (m_axi_arid == 1'b0 && m_axi_arsize == 3'd3 && m_axi_arburst == 2'b01)
                    else fail_check($sformatf("ARID %0d ARSIZE %0d ARBURST %0d",
                                              m_axi_arid, m_axi_arsize, m_axi_arburst));
                ar_pend.push_back(m_axi_araddr);
                ar_total++;
                frame_ars++;
            end
            if (r_fire) begin
                frame_beats++;
                if (m_axi_rlast) begin
                    rlast_total++;
                end
            end
            assert (ar_total - rlast_total <= `DMA_FIFO_BURSTS)
                else fail_check("more bursts outstanding than the unpacker buffer holds");
            if (pix_valid) begin
                assert (pix_sent < cred_granted) else fail_check("pixel sent without a credit");
                assert (exp_pix.size() != 0) else fail_check("pixel sent beyond the frame");
                exp_px = exp_pix.pop_front();
                assert (pix_data == exp_px)
                    else fail_check($sformatf("pixel %0d is %h, expected %h",
                                              pix_sent, pix_data, exp_px));
                pix_sent++;
            end
            if (pix_credit) begin
                cred_granted++;
            end
            if (busy_q && !frame_busy) begin
                assert (frame_ars == cur_bursts)
                    else fail_check($sformatf("frame issued %0d bursts, expected %0d",
                                              frame_ars, cur_bursts));
                assert (frame_beats == cur_bursts * `DMA_BURST_LEN)
                    else fail_check($sformatf("frame_busy fell after %0d beats", frame_beats));
                frames_done++;
            end
            busy_q = frame_busy;
        end
    end

    // memory slave and pixel consumer
    initial begin : bus_driver
        logic [31:0] r;
        addr_t       burst_addr;
        int          beat_idx;
        int          ar_delay;
        logic        in_burst;
        burst_addr = '0;
        beat_idx = 0;
        ar_delay = 0;
        in_burst = 1'b0;
        forever begin
            @(posedge M_AXI_ACLK);
            #1;
            if (M_AXI_ARESETN) begin
                rng = lcg_step(rng);
                r = rng;
                if (ar_fire) begin
                    m_axi_arready = 1'b0;
                    ar_delay = int'(r[25:24]);
                end
                if (m_axi_arvalid && !m_axi_arready) begin
                    if (ar_delay == 0) begin
                        m_axi_arready = 1'b1;
                    end else begin
                        ar_delay--;
                    end
                end
                if (r_fire) begin
                    m_axi_rvalid = 1'b0;
                    if (m_axi_rlast) begin
                        in_burst = 1'b0;
                    end else begin
                        beat_idx++;
                    end
                    m_axi_rlast = 1'b0;
                end
                if (!in_burst && ar_pend.size() != 0) begin
                    burst_addr = ar_pend.pop_front();
                    beat_idx = 0;
                    in_burst = 1'b1;
                end
                // random gaps between beats
                if (in_burst && !m_axi_rvalid && r[29:28] != 2'b00) begin
                    m_axi_rvalid = 1'b1;
                    m_axi_rdata = beat_word(burst_addr + addr_t'(beat_idx * `DMA_DATA_BYTES));
                    m_axi_rlast = (beat_idx == `DMA_BURST_LEN - 1);
                end
                pix_credit = r[20];
            end
        end
    end

    a_not_armed: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        start_pulses < `DMA_ARM_COUNT |-> !m_axi_arvalid && !frame_busy)
        else fail_check("ARVALID or frame_busy seen before the DMA was armed");

    initial begin : stimulus
        M_AXI_ARESETN = 1'b0;
        m_axi_arready = 1'b0;
        m_axi_rdata = '0;
        m_axi_rlast = 1'b0;
        m_axi_rvalid = 1'b0;
        wr_index = 8'd1;
        rd_start = 1'b0;
        ps_access = 1'b0;
        d_size = '0;
        pix_credit = 1'b0;
        repeat (2) @(posedge M_AXI_ACLK);
        #1;
        M_AXI_ARESETN = 1'b1;
        @(negedge M_AXI_ACLK);
        assert (!m_axi_arvalid && !m_axi_rready && !frame_busy && !pix_valid)
            else fail_check("outputs not idle after reset");
        pulse_start();
        pulse_start();
        // access edge while still disarmed
        pulse_access();
        repeat (8) @(posedge M_AXI_ACLK);
        pulse_start();
        pulse_start();
        repeat (8) @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        assert (!frame_busy && !m_axi_arvalid) else fail_check("early access started a frame");
        @(posedge M_AXI_ACLK);
        run_frame(8'd1, 24'd128);
        run_frame(8'd2, 24'd192);
        // 130 pixels, partial burst dropped
        run_frame(8'd3, 24'd130);
        @(negedge M_AXI_ACLK);
        if (!frame_busy && !m_axi_arvalid && !m_axi_rready && !pix_valid) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_check("DUT not idle at the end of the run");
        end
    end

    initial begin : watchdog
        #(CLK_NS * (TOTAL_BEATS * 40 + 400));
        fail_check("watchdog timeout, the frames did not complete");
    end

endmodule

`default_nettype wire
